// File: cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// program counter value after reset
`define CPU_BOOT_VEC 32'h8000_0000

// entries in the fetch to decode queue
`define CPU_IFQ_DEPTH 4

// memory reads allowed in flight at once
`define CPU_MAX_FETCH 2

`endif

// File: cpu_pkg.sv
package cpu_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [31:0] gpreg_t;

  // one fetched word and the address it came from
  typedef struct packed {
    addr_t  pc;
    instr_t instr;
  } fetched_t;

  typedef enum logic [2:0] {
    FMT_R,
    FMT_I,
    FMT_S,
    FMT_B,
    FMT_U,
    FMT_J,
    FMT_ILLEGAL
  } fmt_t;

  // RV32I major opcodes, bits [6:0]
  typedef enum logic [6:0] {
    OPC_LOAD     = 7'b0000011,
    OPC_MISC_MEM = 7'b0001111,
    OPC_OP_IMM   = 7'b0010011,
    OPC_AUIPC    = 7'b0010111,
    OPC_STORE    = 7'b0100011,
    OPC_OP       = 7'b0110011,
    OPC_LUI      = 7'b0110111,
    OPC_BRANCH   = 7'b1100011,
    OPC_JALR     = 7'b1100111,
    OPC_JAL      = 7'b1101111,
    OPC_SYSTEM   = 7'b1110011
  } opcode_t;

  // fields are raw bit slices, imm is sign extended per format
  typedef struct packed {
    addr_t       pc;
    fmt_t        fmt;
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    logic [31:0] imm;
  } decoded_t;

endpackage

// File: instr_queue.sv
`timescale 1ns/1ps

module instr_queue #(
  parameter type payload_t = logic [31:0],
  parameter int DEPTH = 4
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           enq_valid,
  output logic                           enq_ready,
  input  payload_t                       enq_data,
  output logic                           deq_valid,
  input  logic                           deq_ready,
  output payload_t                       deq_data,
  output logic [$clog2(DEPTH + 1)-1:0]   count
);

  localparam int CW = $clog2(DEPTH + 1);
  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  payload_t      mem [DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] cnt;
  logic          enq_fire;
  logic          deq_fire;

  // a full queue still takes a word when the head leaves
  assign enq_ready = (cnt != CW'(DEPTH)) || deq_ready;
  assign deq_valid = (cnt != '0);
  assign deq_data  = mem[rd_ptr];
  assign count     = cnt;

  assign enq_fire = enq_valid && enq_ready;
  assign deq_fire = deq_valid && deq_ready;

  always_ff @(posedge clk) begin
    if (enq_fire) begin
      mem[wr_ptr] <= enq_data;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      cnt    <= '0;
    end else begin
      if (enq_fire) begin
        wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + PW'(1);
      end
      if (deq_fire) begin
        rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + PW'(1);
      end
      case ({enq_fire, deq_fire})
        2'b10:   cnt <= cnt + CW'(1);
        2'b01:   cnt <= cnt - CW'(1);
        default: cnt <= cnt;
      endcase
    end
  end

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module fetch_unit (
  input  logic                                      clk,
  input  logic                                      rst,
  output logic                                      mem_req_valid,
  input  logic                                      mem_req_ready,
  output cpu_pkg::addr_t                            mem_req_addr,
  input  logic                                      mem_resp_valid,
  output logic                                      mem_resp_ready,
  input  cpu_pkg::instr_t                           mem_resp_data,
  output logic                                      enq_valid,
  input  logic                                      enq_ready,
  output cpu_pkg::fetched_t                         enq_data,
  input  logic [$clog2(`CPU_IFQ_DEPTH + 1)-1:0]     q_count
);

  import cpu_pkg::*;

  localparam int MAX_FETCH = `CPU_MAX_FETCH;
  localparam int OW = $clog2(MAX_FETCH + 1);
  localparam int PW = (MAX_FETCH > 1) ? $clog2(MAX_FETCH) : 1;

  addr_t         pc;
  addr_t         pend_pc [MAX_FETCH];
  logic [PW-1:0] pend_wr;
  logic [PW-1:0] pend_rd;
  logic [OW-1:0] outstanding;
  logic          room_in_flight;
  logic          room_in_queue;
  logic          req_fire;
  logic          resp_fire;

  // every read in flight needs a free queue slot when it returns
  assign room_in_flight = outstanding < OW'(MAX_FETCH);
  assign room_in_queue  = (int'(q_count) + int'(outstanding)) < `CPU_IFQ_DEPTH;

  assign mem_req_valid = room_in_flight && room_in_queue;
  assign mem_req_addr  = pc;
  assign req_fire      = mem_req_valid && mem_req_ready;

  // responses go straight into the queue
  assign mem_resp_ready = enq_ready;
  assign resp_fire      = mem_resp_valid && mem_resp_ready;
  assign enq_valid      = mem_resp_valid;
  assign enq_data       = '{pc: pend_pc[pend_rd], instr: mem_resp_data};

  always_ff @(posedge clk) begin
    if (req_fire) begin
      pend_pc[pend_wr] <= pc;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc          <= `CPU_BOOT_VEC;
      pend_wr     <= '0;
      pend_rd     <= '0;
      outstanding <= '0;
    end else begin
      if (req_fire) begin
        pc      <= pc + 32'd4;
        pend_wr <= (pend_wr == PW'(MAX_FETCH - 1)) ? '0 : pend_wr + PW'(1);
      end
      if (resp_fire) begin
        pend_rd <= (pend_rd == PW'(MAX_FETCH - 1)) ? '0 : pend_rd + PW'(1);
      end
      case ({req_fire, resp_fire})
        2'b10:   outstanding <= outstanding + OW'(1);
        2'b01:   outstanding <= outstanding - OW'(1);
        default: outstanding <= outstanding;
      endcase
    end
  end

endmodule

// File: regfile.sv
`timescale 1ns/1ps

module regfile (
  input  logic              clk,
  input  logic              rst,
  input  cpu_pkg::reg_idx_t rd_idx_a,
  input  cpu_pkg::reg_idx_t rd_idx_b,
  output cpu_pkg::gpreg_t   rd_val_a,
  output cpu_pkg::gpreg_t   rd_val_b,
  input  logic              wr_en,
  input  cpu_pkg::reg_idx_t wr_idx,
  input  cpu_pkg::gpreg_t   wr_val
);

  import cpu_pkg::*;

  // x0 has no storage
  gpreg_t regs [1:31];
  logic   wr_live;
  logic   hit_a;
  logic   hit_b;

  assign wr_live = wr_en && (wr_idx != '0);

  // same-cycle write is forwarded to the read ports
  assign hit_a = wr_live && (wr_idx == rd_idx_a);
  assign hit_b = wr_live && (wr_idx == rd_idx_b);

  always_comb begin
    if (rd_idx_a == '0) begin
      rd_val_a = '0;
    end else if (hit_a) begin
      rd_val_a = wr_val;
    end else begin
      rd_val_a = regs[rd_idx_a];
    end
  end

  always_comb begin
    if (rd_idx_b == '0) begin
      rd_val_b = '0;
    end else if (hit_b) begin
      rd_val_b = wr_val;
    end else begin
      rd_val_b = regs[rd_idx_b];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr_idx] <= wr_val;
    end
  end

endmodule

// File: instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
  input  logic               clk,
  input  logic               rst,
  input  logic               deq_valid,
  output logic               deq_ready,
  input  cpu_pkg::fetched_t  deq_data,
  output cpu_pkg::reg_idx_t  rs1_idx,
  output cpu_pkg::reg_idx_t  rs2_idx,
  input  cpu_pkg::gpreg_t    rs1_val,
  input  cpu_pkg::gpreg_t    rs2_val,
  output logic               dec_valid,
  input  logic               dec_ready,
  output cpu_pkg::decoded_t  dec_data,
  output cpu_pkg::gpreg_t    dec_rs1_val,
  output cpu_pkg::gpreg_t    dec_rs2_val
);

  import cpu_pkg::*;

  decoded_t held_q;
  logic     held_valid_q;
  logic     load;

  function automatic decoded_t decode(input fetched_t f);
    decoded_t d;
    instr_t   w;
    w        = f.instr;
    d.pc     = f.pc;
    d.opcode = w[6:0];
    d.rd     = w[11:7];
    d.funct3 = w[14:12];
    d.rs1    = w[19:15];
    d.rs2    = w[24:20];
    d.funct7 = w[31:25];

    case (w[6:0])
      OPC_OP:                                           d.fmt = FMT_R;
      OPC_OP_IMM, OPC_LOAD, OPC_JALR, OPC_MISC_MEM,
      OPC_SYSTEM:                                       d.fmt = FMT_I;
      OPC_STORE:                                        d.fmt = FMT_S;
      OPC_BRANCH:                                       d.fmt = FMT_B;
      OPC_LUI, OPC_AUIPC:                               d.fmt = FMT_U;
      OPC_JAL:                                          d.fmt = FMT_J;
      default:                                          d.fmt = FMT_ILLEGAL;
    endcase

    // immediate bits scattered per format, sign taken from bit 31
    case (d.fmt)
      FMT_I:   d.imm = {{20{w[31]}}, w[31:20]};
      FMT_S:   d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      FMT_B:   d.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      FMT_U:   d.imm = {w[31:12], 12'b0};
      FMT_J:   d.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      default: d.imm = '0;
    endcase
    return d;
  endfunction

  // take a new head when the slot is empty or draining this cycle
  assign deq_ready = !held_valid_q || dec_ready;
  assign load      = deq_valid && deq_ready;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      held_valid_q <= 1'b0;
    end else if (load) begin
      held_valid_q <= 1'b1;
    end else if (dec_ready) begin
      held_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      held_q <= decode(deq_data);
    end
  end

  // operands follow the held instruction, bypass comes from the regfile
  assign rs1_idx     = held_q.rs1;
  assign rs2_idx     = held_q.rs2;
  assign dec_rs1_val = rs1_val;
  assign dec_rs2_val = rs2_val;

  assign dec_valid = held_valid_q;
  assign dec_data  = held_q;

endmodule

// File: cpu_frontend.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_frontend (
  input  logic              clk,
  input  logic              rst,
  output logic              mem_req_valid,
  input  logic              mem_req_ready,
  output cpu_pkg::addr_t    mem_req_addr,
  input  logic              mem_resp_valid,
  output logic              mem_resp_ready,
  input  cpu_pkg::instr_t   mem_resp_data,
  input  logic              wb_en,
  input  cpu_pkg::reg_idx_t wb_idx,
  input  cpu_pkg::gpreg_t   wb_val,
  output logic              dec_valid,
  input  logic              dec_ready,
  output cpu_pkg::decoded_t dec_data,
  output cpu_pkg::gpreg_t   dec_rs1_val,
  output cpu_pkg::gpreg_t   dec_rs2_val
);

  import cpu_pkg::*;

  localparam int QCW = $clog2(`CPU_IFQ_DEPTH + 1);

  // fetch to queue
  logic           enq_valid;
  logic           enq_ready;
  fetched_t       enq_data;
  logic [QCW-1:0] q_count;

  // queue to decode
  logic           deq_valid;
  logic           deq_ready;
  fetched_t       deq_data;

  // decode to register file
  reg_idx_t       rs1_idx;
  reg_idx_t       rs2_idx;
  gpreg_t         rs1_val;
  gpreg_t         rs2_val;

  fetch_unit fetch_inst (
    .clk            (clk),
    .rst            (rst),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_addr   (mem_req_addr),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_ready (mem_resp_ready),
    .mem_resp_data  (mem_resp_data),
    .enq_valid      (enq_valid),
    .enq_ready      (enq_ready),
    .enq_data       (enq_data),
    .q_count        (q_count)
  );

  instr_queue #(
    .payload_t (fetched_t),
    .DEPTH     (`CPU_IFQ_DEPTH)
  ) ifq_inst (
    .clk       (clk),
    .rst       (rst),
    .enq_valid (enq_valid),
    .enq_ready (enq_ready),
    .enq_data  (enq_data),
    .deq_valid (deq_valid),
    .deq_ready (deq_ready),
    .deq_data  (deq_data),
    .count     (q_count)
  );

  instr_decode decode_inst (
    .clk         (clk),
    .rst         (rst),
    .deq_valid   (deq_valid),
    .deq_ready   (deq_ready),
    .deq_data    (deq_data),
    .rs1_idx     (rs1_idx),
    .rs2_idx     (rs2_idx),
    .rs1_val     (rs1_val),
    .rs2_val     (rs2_val),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec_data    (dec_data),
    .dec_rs1_val (dec_rs1_val),
    .dec_rs2_val (dec_rs2_val)
  );

  regfile regfile_inst (
    .clk      (clk),
    .rst      (rst),
    .rd_idx_a (rs1_idx),
    .rd_idx_b (rs2_idx),
    .rd_val_a (rs1_val),
    .rd_val_b (rs2_val),
    .wr_en    (wb_en),
    .wr_idx   (wb_idx),
    .wr_val   (wb_val)
  );

endmodule

// File: tb_mem_model.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_mem_model (
  input  logic            clk,
  input  logic            rst,
  input  logic            req_valid,
  output logic            req_ready,
  input  cpu_pkg::addr_t  req_addr,
  output logic            resp_valid,
  input  logic            resp_ready,
  output cpu_pkg::instr_t resp_data
);

  import cpu_pkg::*;

  localparam int WORDS = 64;

  instr_t image [WORDS];
  addr_t  pend_addr [$];
  int     pend_due [$];
  int     cycle;
  addr_t  head_addr;

  // eleven RV32I opcodes, then two that decode as illegal
  function automatic logic [6:0] pick_opcode(input int k);
    case (k)
      0:       return 7'h33;
      1:       return 7'h13;
      2:       return 7'h03;
      3:       return 7'h23;
      4:       return 7'h63;
      5:       return 7'h37;
      6:       return 7'h17;
      7:       return 7'h6f;
      8:       return 7'h67;
      9:       return 7'h0f;
      10:      return 7'h73;
      11:      return 7'h7f;
      default: return 7'h0b;
    endcase
  endfunction

  initial begin
    addr_t       a;
    logic [31:0] h;
    for (int i = 0; i < WORDS; i++) begin
      a = `CPU_BOOT_VEC + 32'(4 * i);
      // upper bits scrambled from the full address
      h = a * 32'h9e37_79b9;
      h = h ^ (h >> 13) ^ {a[15:0], a[31:16]};
      image[i] = {h[31:7], pick_opcode(i % 13)};
    end
    req_ready  = 1'b0;
    resp_valid = 1'b0;
    resp_data  = '0;
    cycle      = 0;
  end

  always @(posedge clk or posedge rst) begin
    if (rst) begin
      pend_addr.delete();
      pend_due.delete();
      cycle = 0;
      req_ready  <= 1'b0;
      resp_valid <= 1'b0;
    end else begin
      cycle = cycle + 1;
      if (req_valid && req_ready) begin
        pend_addr.push_back(req_addr);
        pend_due.push_back(cycle + int'($urandom_range(1, 5)));
      end
      if (resp_valid && resp_ready) begin
        void'(pend_addr.pop_front());
        void'(pend_due.pop_front());
      end
      req_ready <= ($urandom_range(0, 3) != 0);
      // oldest read goes out once its latency has passed
      if (pend_addr.size() > 0 && pend_due[0] <= cycle) begin
        head_addr = pend_addr[0];
        resp_valid <= 1'b1;
        resp_data  <= image[head_addr[7:2]];
      end else begin
        resp_valid <= 1'b0;
      end
    end
  end

endmodule

// File: tb_cpu_frontend.sv
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu_frontend;

  import cpu_pkg::*;

  localparam int HALF_PERIOD  = 50;
  localparam int N_INSTR      = 64;
  localparam int FIRST_RUN    = 20;
  localparam int STALL_CYCLES = 30;
  localparam int WORST_CYCLES = 40;
  localparam int TIMEOUT_NS   = (FIRST_RUN + 8 + N_INSTR) * WORST_CYCLES * 2 * HALF_PERIOD;

  logic     clk;
  logic     rst;
  logic     mem_req_valid;
  logic     mem_req_ready;
  addr_t    mem_req_addr;
  logic     mem_resp_valid;
  logic     mem_resp_ready;
  instr_t   mem_resp_data;
  logic     wb_en;
  reg_idx_t wb_idx;
  gpreg_t   wb_val;
  logic     dec_valid;
  logic     dec_ready;
  decoded_t dec_data;
  gpreg_t   dec_rs1_val;
  gpreg_t   dec_rs2_val;

  gpreg_t   shadow [32];
  decoded_t exp_dec;
  addr_t    exp_pc;
  int       n_decoded;
  int       issued;
  int       retired;
  int       in_pipe;
  logic     hold_dec;

  cpu_frontend cpu_frontend_inst (
    .clk            (clk),
    .rst            (rst),
    .mem_req_valid  (mem_req_valid),
    .mem_req_ready  (mem_req_ready),
    .mem_req_addr   (mem_req_addr),
    .mem_resp_valid (mem_resp_valid),
    .mem_resp_ready (mem_resp_ready),
    .mem_resp_data  (mem_resp_data),
    .wb_en          (wb_en),
    .wb_idx         (wb_idx),
    .wb_val         (wb_val),
    .dec_valid      (dec_valid),
    .dec_ready      (dec_ready),
    .dec_data       (dec_data),
    .dec_rs1_val    (dec_rs1_val),
    .dec_rs2_val    (dec_rs2_val)
  );

  tb_mem_model mem_inst (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (mem_req_valid),
    .req_ready  (mem_req_ready),
    .req_addr   (mem_req_addr),
    .resp_valid (mem_resp_valid),
    .resp_ready (mem_resp_ready),
    .resp_data  (mem_resp_data)
  );

  always #HALF_PERIOD clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, expected);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopping at first mismatch");
    end
  endtask

  // RV32I base formats, immediates sign extended from bit 31
  function automatic decoded_t ref_decode(input logic [31:0] w, input logic [31:0] pc);
    decoded_t r;
    r.pc     = pc;
    r.opcode = w[6:0];
    r.rd     = w[11:7];
    r.funct3 = w[14:12];
    r.rs1    = w[19:15];
    r.rs2    = w[24:20];
    r.funct7 = w[31:25];
    r.imm    = 32'd0;
    case (w[6:0])
      7'h33: r.fmt = FMT_R;
      7'h03, 7'h0f, 7'h13, 7'h67, 7'h73: begin
        r.fmt = FMT_I;
        r.imm = {{21{w[31]}}, w[30:20]};
      end
      7'h23: begin
        r.fmt = FMT_S;
        r.imm = {{21{w[31]}}, w[30:25], w[11:7]};
      end
      7'h63: begin
        r.fmt = FMT_B;
        r.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      end
      7'h37, 7'h17: begin
        r.fmt = FMT_U;
        r.imm = {w[31:12], 12'h000};
      end
      7'h6f: begin
        r.fmt = FMT_J;
        r.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      end
      default: r.fmt = FMT_ILLEGAL;
    endcase
    return r;
  endfunction

  // register value seen this cycle, a write in flight counts
  function automatic gpreg_t read_shadow(input reg_idx_t idx);
    if (idx == '0) begin
      return '0;
    end else if (wb_en && wb_idx == idx) begin
      return wb_val;
    end
    return shadow[idx];
  endfunction

  task automatic wait_decoded(input int n);
    while (n_decoded < n) begin
      @(posedge clk);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      dec_ready <= 1'b0;
      wb_en     <= 1'b0;
    end else begin
      dec_ready <= !hold_dec && ($urandom_range(0, 3) != 0);
      wb_en     <= ($urandom_range(0, 1) == 1);
      wb_val    <= $urandom;
      // aim writes at the held operands often, to hit the bypass
      case ($urandom_range(0, 3))
        0:       wb_idx <= dec_valid ? dec_data.rs1 : reg_idx_t'($urandom_range(1, 31));
        1:       wb_idx <= dec_valid ? dec_data.rs2 : reg_idx_t'($urandom_range(1, 31));
        2:       wb_idx <= '0;
        default: wb_idx <= reg_idx_t'($urandom_range(1, 31));
      endcase
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        shadow[i] = '0;
      end
      exp_pc    = `CPU_BOOT_VEC;
      n_decoded = 0;
      issued    = 0;
      retired   = 0;
    end else begin
      // reads in flight plus queued words, held slot excluded
      in_pipe = issued - retired - int'(dec_valid);
      if (mem_req_valid) begin
        check_value("in_pipe below queue depth", 32'(in_pipe < `CPU_IFQ_DEPTH), 32'd1);
      end
      // every read in flight has a queue slot kept for it
      if (mem_resp_valid) begin
        check_value("mem_resp_ready", mem_resp_ready, 32'd1);
      end
      if (mem_req_valid && mem_req_ready) begin
        check_value("mem_req_addr", mem_req_addr, `CPU_BOOT_VEC + 32'(4 * issued));
        issued = issued + 1;
      end
      if (dec_valid && dec_ready) begin
        exp_dec = ref_decode(mem_inst.image[exp_pc[7:2]], exp_pc);
        check_value("dec_data.pc", dec_data.pc, exp_dec.pc);
        check_value("dec_data.fmt", 32'(dec_data.fmt), 32'(exp_dec.fmt));
        check_value("dec_data.opcode", dec_data.opcode, exp_dec.opcode);
        check_value("dec_data.funct3", dec_data.funct3, exp_dec.funct3);
        check_value("dec_data.funct7", dec_data.funct7, exp_dec.funct7);
        check_value("dec_data.rd", dec_data.rd, exp_dec.rd);
        check_value("dec_data.rs1", dec_data.rs1, exp_dec.rs1);
        check_value("dec_data.rs2", dec_data.rs2, exp_dec.rs2);
        check_value("dec_data.imm", dec_data.imm, exp_dec.imm);
        check_value("dec_rs1_val", dec_rs1_val, read_shadow(exp_dec.rs1));
        check_value("dec_rs2_val", dec_rs2_val, read_shadow(exp_dec.rs2));
        retired   = retired + 1;
        n_decoded = n_decoded + 1;
        exp_pc    = exp_pc + 32'd4;
      end
      if (wb_en && wb_idx != '0) begin
        shadow[wb_idx] = wb_val;
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    $display("*** TEST FAILED ***");
    $fatal(1, "watchdog expired after %0d ns, %0d instructions decoded", TIMEOUT_NS, n_decoded);
  end

  initial begin
    void'($urandom(32'hbee9));
    clk       = 1'b0;
    rst       = 1'b1;
    dec_ready = 1'b0;
    wb_en     = 1'b0;
    wb_idx    = '0;
    wb_val    = '0;
    hold_dec  = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    wait_decoded(FIRST_RUN);

    // output held back, queue and reads in flight fill up
    hold_dec <= 1'b1;
    repeat (STALL_CYCLES) @(posedge clk);
    check_value("mem_req_valid", mem_req_valid, 32'd0);
    check_value("dec_valid", dec_valid, 32'd1);
    hold_dec <= 1'b0;
    wait_decoded(FIRST_RUN + 8);

    // reset in the middle of the stream
    @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    check_value("dec_valid", dec_valid, 32'd0);
    check_value("mem_req_addr", mem_req_addr, `CPU_BOOT_VEC);
    rst <= 1'b0;
    wait_decoded(N_INSTR);
    repeat (4) @(posedge clk);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: cpu_frontend.f
+incdir+.
cpu_pkg.sv
instr_queue.sv
fetch_unit.sv
regfile.sv
instr_decode.sv
cpu_frontend.sv
tb_mem_model.sv
tb_cpu_frontend.sv
